// File: elem_drive_top.f
+incdir+verilog
verilog/elem_drive_pkg.sv
verilog/elem_cmd_decode.sv
verilog/env_addr_seq.sv
verilog/wave_table.sv
verilog/amp_modulator.sv
verilog/elem_sum.sv
verilog/elem_drive_top.sv
verif/elem_drive_tb.sv

// File: verif/elem_drive_tests.txt
# w sel addr x y : table write, sel 0 envelope 1 carrier (x cos, y sin), hex
# t name len : new test, commands are strobed within the first len cycles
# c elem offset env_start env_len frq_base amp : command, offset in cycles, fields hex
# e n x y ... : n expected output samples in order, hex, then the test runs
w 0 00 2000 1000
w 0 01 4000 f000
w 0 02 1000 3000
w 0 03 e000 0800
w 0 04 6000 a000
w 0 05 0100 0200
w 0 fe 0400 0000
w 0 ff 0800 0400
w 1 00 4000 0000
w 1 01 0000 4000
w 1 02 c000 0000
w 1 03 4000 4000
w 1 04 7fff 0000
w 1 05 4000 0000
w 1 fe 4000 0000
w 1 ff 0000 4000
t single 1
c 0 0 00 04 00 7fff
e 4 0fff 07ff 07ff 1fff f800 e800 ec00 f400
t half_amp 1
c 0 0 00 04 00 4000
e 4 0800 0400 0400 1000 fc00 f400 f600 fa00
t neg_amp 1
c 1 0 00 04 00 c000
e 4 f800 fc00 fc00 f000 0400 0c00 0a00 0600
t wrap 1
c 0 0 fe 04 fe 7fff
e 4 01ff 0000 fe00 03ff 0fff 07ff 07ff 1fff
t sum 3
c 0 0 02 03 02 7fff
c 1 2 04 02 04 7fff
e 4 f800 e800 ec00 f400 bffc 4000 007f 00ff
t ignored 3
c 0 0 00 04 00 7fff
c 0 2 fe 02 fe 4000
e 4 0fff 07ff 07ff 1fff f800 e800 ec00 f400
t zero_len 1
c 1 0 10 00 20 7fff
e 0

// File: verif/elem_drive_tb.sv
// testbench for the drive generator, replays table writes and pulses from the test file and checks out_iq
`timescale 1ns/100ps
`include "elem_drive_cfg.svh"

module elem_drive_tb;
	import elem_drive_pkg::*;

	localparam int MAX_CMD = 4;
	localparam int MAX_GAP = 8;      // longest idle gap between tests

	logic      elem;
	logic      rst_n;
	logic      tbl_we;
	tbl_wr_t   tbl_wr;
	logic      cmd_stb0;
	elem_cmd_t cmd0;
	logic      cmd_stb1;
	elem_cmd_t cmd1;
	logic      busy0;
	logic      busy1;
	logic      out_valid;
	iq_t       out_iq;

	int     cyc;
	int     errors;
	int     checks;
	int     budget = 205;        // cycle limit, grows with every record read
	integer seed;

	// current test, filled by the file reader
	int        n_cmd;
	int        c_elem [MAX_CMD];
	int        c_off [MAX_CMD];
	elem_cmd_t c_cmd [MAX_CMD];
	iq_t       exp_q [$];

	iq_t got_iq [$];
	int  got_cyc [$];    // posedge index of each collected sample

	elem_drive_top DUT (
		.elem(elem), .rst_n(rst_n), .tbl_we(tbl_we), .tbl_wr(tbl_wr),
		.cmd_stb0(cmd_stb0), .cmd0(cmd0), .cmd_stb1(cmd_stb1), .cmd1(cmd1),
		.busy0(busy0), .busy1(busy1), .out_valid(out_valid), .out_iq(out_iq)
	);

	initial begin
		elem = 1'b0;
		forever #2 elem = ~elem;
	end

	always @(posedge elem)
		cyc <= cyc + 1;

	// output monitor
	always @(negedge elem) begin
		if (out_valid === 1'b1) begin
			got_iq.push_back(out_iq);
			got_cyc.push_back(cyc);
		end
	end

	task automatic check_value(input [8*24-1:0] tname, input [8*8-1:0] what, input int idx,
			input [31:0] exp, input [31:0] act);
		checks++;
		if (exp !== act) begin
			errors++;
			$display("[FAIL] %0s %0s %0d: expected %h, actual %h", tname, what, idx, exp, act);
		end
	endtask

	task automatic write_table(input logic sel, input logic [7:0] addr, input iq_t data);
		tbl_we = 1'b1;
		tbl_wr = {sel, addr, data};
		@(negedge elem);
		tbl_we = 1'b0;
	endtask

	task automatic run_pulse_test(input [8*24-1:0] tname, input int len);
		int gap;
		int base;
		int first;
		int k;
		int j;
		gap = 1 + ($unsigned($random(seed)) % MAX_GAP);
		repeat (gap) @(negedge elem);
		got_iq.delete();
		got_cyc.delete();
		first = len;
		for (j = 0; j < n_cmd; j++)
			if (c_off[j] < first)
				first = c_off[j];
		base = cyc;
		for (k = 0; k < len; k++) begin
			cmd_stb0 = 1'b0;
			cmd_stb1 = 1'b0;
			for (j = 0; j < n_cmd; j++) begin
				if (c_off[j] == k && c_elem[j] == 0) begin
					cmd_stb0 = 1'b1;
					cmd0 = c_cmd[j];
				end else if (c_off[j] == k) begin
					cmd_stb1 = 1'b1;
					cmd1 = c_cmd[j];
				end
			end
			@(negedge elem);
			if (cmd_stb0)
				check_value(tname, "busy0", k, 1, busy0);    // set by the strobe, or already set
			if (cmd_stb1)
				check_value(tname, "busy1", k, 1, busy1);
		end
		cmd_stb0 = 1'b0;
		cmd_stb1 = 1'b0;
		// pulses drain through table, modulator and summer
		while (busy0 || busy1 || out_valid)
			@(negedge elem);
		check_value(tname, "count", 0, exp_q.size(), got_iq.size());
		for (j = 0; j < exp_q.size() && j < got_iq.size(); j++) begin
			check_value(tname, "sample", j, exp_q[j], got_iq[j]);
			// strobe edge is base+offset+1, samples follow back to back
			check_value(tname, "cycle", j, base + first + 1 + `DRIVE_LAT + j, got_cyc[j]);
		end
	endtask

	initial begin : main
		integer fd;
		integer code;
		reg [8*16-1:0]  kw;
		reg [8*24-1:0]  tname;
		reg [8*200-1:0] line;
		int len;
		int n_exp;
		int i;
		integer f_el;
		integer f_off;
		logic [31:0] f_a;
		logic [31:0] f_b;
		logic [31:0] f_c;
		logic [31:0] f_d;
		seed = 97104;
		errors = 0;
		checks = 0;
		rst_n = 1'b0;
		tbl_we = 1'b0;
		tbl_wr = '0;
		cmd_stb0 = 1'b0;
		cmd0 = '0;
		cmd_stb1 = 1'b0;
		cmd1 = '0;
		repeat (5) @(posedge elem);
		@(negedge elem);
		rst_n = 1'b1;
		fd = $fopen("verif/elem_drive_tests.txt", "r");
		if (fd == 0) begin
			$display("cannot open verif/elem_drive_tests.txt, no test was run");
			errors++;
		end else begin
			while ($fscanf(fd, "%s", kw) == 1) begin
				if (kw == "#") begin
					code = $fgets(line, fd);
				end else if (kw == "w") begin
					code = $fscanf(fd, "%h %h %h %h", f_a, f_b, f_c, f_d);
					budget += 1;
					write_table(f_a[0], f_b[7:0], {f_c[15:0], f_d[15:0]});
				end else if (kw == "t") begin
					code = $fscanf(fd, "%s %d", tname, len);
					n_cmd = 0;
					exp_q.delete();
					budget += len + MAX_GAP;
				end else if (kw == "c") begin
					code = $fscanf(fd, "%d %d %h %h %h %h", f_el, f_off, f_a, f_b, f_c, f_d);
					if (n_cmd == MAX_CMD) begin
						$display("too many commands in test %0s, command dropped", tname);
						errors++;
					end else begin
						c_elem[n_cmd] = f_el;
						c_off[n_cmd] = f_off;
						c_cmd[n_cmd] = {f_a[7:0], f_b[7:0], f_c[7:0], f_d[15:0]};
						n_cmd++;
						budget += f_b[7:0] + `DRIVE_LAT + 2;
					end
				end else if (kw == "e") begin
					code = $fscanf(fd, "%d", n_exp);
					for (i = 0; i < n_exp; i++) begin
						code = $fscanf(fd, "%h %h", f_a, f_b);
						exp_q.push_back({f_a[15:0], f_b[15:0]});
					end
					run_pulse_test(tname, len);
				end else begin
					$display("unknown record %0s in the test file", kw);
					errors++;
					code = $fgets(line, fd);
				end
			end
			$fclose(fd);
		end
		if (checks == 0) begin
			$display("no check was run");
			errors++;
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial begin : watchdog
		@(posedge elem);
		while (cyc < budget)
			@(posedge elem);
		$display("timeout after %0d cycles, the test sequence did not finish", cyc);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: verilog/elem_drive_top.sv
// two element qubit drive generator top, command decode, sequencer, modulator per element into a summer
`timescale 1ns/100ps

module elem_drive_top (
	input  logic                      elem,
	input  logic                      rst_n,
	input  logic                      tbl_we,
	input  elem_drive_pkg::tbl_wr_t   tbl_wr,
	input  logic                      cmd_stb0,
	input  elem_drive_pkg::elem_cmd_t cmd0,
	input  logic                      cmd_stb1,
	input  elem_drive_pkg::elem_cmd_t cmd1,
	output logic                      busy0,
	output logic                      busy1,
	output logic                      out_valid,
	output elem_drive_pkg::iq_t       out_iq
);
	import elem_drive_pkg::*;

	// element 0 chain
	logic      start0;
	elem_cmd_t cmd_q0;
	logic      done0;
	env_addr_t env_addr0;
	frq_addr_t frq_addr0;
	logic      gate0;
	iq_t       env_iq0;
	iq_t       frq_iq0;
	logic      mod_valid0;
	iq_t       mod_iq0;

	// element 1 chain
	logic      start1;
	elem_cmd_t cmd_q1;
	logic      done1;
	env_addr_t env_addr1;
	frq_addr_t frq_addr1;
	logic      gate1;
	iq_t       env_iq1;
	iq_t       frq_iq1;
	logic      mod_valid1;
	iq_t       mod_iq1;

	elem_cmd_decode u_dec0 (
		.elem(elem), .rst_n(rst_n), .cmd_stb(cmd_stb0), .cmd(cmd0), .done(done0),
		.start(start0), .cmd_q(cmd_q0), .busy(busy0)
	);

	elem_cmd_decode u_dec1 (
		.elem(elem), .rst_n(rst_n), .cmd_stb(cmd_stb1), .cmd(cmd1), .done(done1),
		.start(start1), .cmd_q(cmd_q1), .busy(busy1)
	);

	env_addr_seq u_seq0 (
		.elem(elem), .rst_n(rst_n), .start(start0), .cmd_q(cmd_q0),
		.env_addr(env_addr0), .frq_addr(frq_addr0), .gate(gate0), .done(done0)
	);

	env_addr_seq u_seq1 (
		.elem(elem), .rst_n(rst_n), .start(start1), .cmd_q(cmd_q1),
		.env_addr(env_addr1), .frq_addr(frq_addr1), .gate(gate1), .done(done1)
	);

	// shared tables, one read port pair per element
	wave_table u_tbl (
		.elem(elem), .tbl_we(tbl_we), .tbl_wr(tbl_wr),
		.env_addr0(env_addr0), .env_addr1(env_addr1),
		.frq_addr0(frq_addr0), .frq_addr1(frq_addr1),
		.env_iq0(env_iq0), .env_iq1(env_iq1),
		.frq_iq0(frq_iq0), .frq_iq1(frq_iq1)
	);

	amp_modulator u_mod0 (
		.elem(elem), .rst_n(rst_n), .gate(gate0), .env_iq(env_iq0), .frq_iq(frq_iq0),
		.amp(cmd_q0.amp), .mod_valid(mod_valid0), .mod_iq(mod_iq0)
	);

	amp_modulator u_mod1 (
		.elem(elem), .rst_n(rst_n), .gate(gate1), .env_iq(env_iq1), .frq_iq(frq_iq1),
		.amp(cmd_q1.amp), .mod_valid(mod_valid1), .mod_iq(mod_iq1)
	);

	elem_sum u_sum (
		.elem(elem), .rst_n(rst_n),
		.valid0(mod_valid0), .valid1(mod_valid1),
		.iq0(mod_iq0), .iq1(mod_iq1),
		.out_valid(out_valid), .out_iq(out_iq)
	);

endmodule

// File: verilog/elem_sum.sv
// sums the two element streams with 16 bit wraparound into the single output stream
`timescale 1ns/100ps

module elem_sum (
	input  logic                elem,
	input  logic                rst_n,
	input  logic                valid0,
	input  logic                valid1,
	input  elem_drive_pkg::iq_t iq0,
	input  elem_drive_pkg::iq_t iq1,
	output logic                out_valid,
	output elem_drive_pkg::iq_t out_iq
);
	import elem_drive_pkg::*;

	iq_t a0;
	iq_t a1;

	// an idle element adds nothing
	assign a0 = valid0 ? iq0 : '0;
	assign a1 = valid1 ? iq1 : '0;

	// no overflow check, sums wrap
	always_ff @(posedge elem) begin
		out_iq.x <= a0.x + a1.x;
		out_iq.y <= a0.y + a1.y;
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else
			out_valid <= valid0 | valid1;
	end

endmodule

// File: verilog/amp_modulator.sv
// per element modulator, envelope times carrier then times amplitude, two register stages
`timescale 1ns/100ps
`include "elem_drive_cfg.svh"

module amp_modulator (
	input  logic                 elem,
	input  logic                 rst_n,
	input  logic                 gate,
	input  elem_drive_pkg::iq_t  env_iq,
	input  elem_drive_pkg::iq_t  frq_iq,
	input  elem_drive_pkg::amp_t amp,
	output logic                 mod_valid,
	output elem_drive_pkg::iq_t  mod_iq
);
	import elem_drive_pkg::*;

	sample_t ex;
	sample_t ey;
	sample_t fc;
	sample_t fs;
	logic signed [2*`SAMPLE_W:0]   px_full;
	logic signed [2*`SAMPLE_W:0]   py_full;
	logic signed [2*`SAMPLE_W-1:0] sx_full;
	logic signed [2*`SAMPLE_W-1:0] sy_full;
	logic gate_d;          // lines up with the table read data
	logic valid_p;         // lines up with prod_d
	iq_t  prod_d;

	// Q1.15 renormalize, arithmetic shift then keep the low 16 bits
	function automatic sample_t q15(input logic signed [2*`SAMPLE_W:0] v);
		return sample_t'(v >>> 15);
	endfunction

	assign ex = env_iq.x;
	assign ey = env_iq.y;
	assign fc = frq_iq.x;
	assign fs = frq_iq.y;

	// stage 1 complex product, full width before the shift
	assign px_full = ex * fc - ey * fs;
	assign py_full = ex * fs + ey * fc;

	// stage 2 amplitude
	assign sx_full = prod_d.x * amp;
	assign sy_full = prod_d.y * amp;

	always_ff @(posedge elem) begin
		prod_d.x <= q15(px_full);
		prod_d.y <= q15(py_full);
		mod_iq.x <= q15(sx_full);
		mod_iq.y <= q15(sy_full);
	end

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			gate_d <= 1'b0;
			valid_p <= 1'b0;
			mod_valid <= 1'b0;
		end else begin
			gate_d <= gate;
			valid_p <= gate_d;
			mod_valid <= valid_p;
		end
	end

endmodule

// File: verilog/wave_table.sv
// shared envelope and carrier tables, host written, with one registered read port per element
`timescale 1ns/100ps
`include "elem_drive_cfg.svh"

module wave_table (
	input  logic                      elem,
	input  logic                      tbl_we,
	input  elem_drive_pkg::tbl_wr_t   tbl_wr,
	input  elem_drive_pkg::env_addr_t env_addr0,
	input  elem_drive_pkg::env_addr_t env_addr1,
	input  elem_drive_pkg::frq_addr_t frq_addr0,
	input  elem_drive_pkg::frq_addr_t frq_addr1,
	output elem_drive_pkg::iq_t       env_iq0,
	output elem_drive_pkg::iq_t       env_iq1,
	output elem_drive_pkg::iq_t       frq_iq0,
	output elem_drive_pkg::iq_t       frq_iq1
);
	import elem_drive_pkg::*;

	iq_t env_mem [`ENV_DEPTH];     // envelope x,y
	iq_t frq_mem [`FRQ_DEPTH];     // carrier cos,sin

	// one word per strobe cycle, sel picks the table
	always_ff @(posedge elem) begin
		if (tbl_we) begin
			if (tbl_wr.sel)
				frq_mem[tbl_wr.addr] <= tbl_wr.data;
			else
				env_mem[tbl_wr.addr] <= tbl_wr.data;
		end
	end

	// element 0 read port
	always_ff @(posedge elem) begin
		env_iq0 <= env_mem[env_addr0];
		frq_iq0 <= frq_mem[frq_addr0];
	end

	// element 1 read port
	always_ff @(posedge elem) begin
		env_iq1 <= env_mem[env_addr1];
		frq_iq1 <= frq_mem[frq_addr1];
	end

endmodule

// File: verilog/env_addr_seq.sv
// per element address sequencer that walks env_start+n and frq_base+n for n below env_len
`timescale 1ns/100ps

module env_addr_seq (
	input  logic                      elem,
	input  logic                      rst_n,
	input  logic                      start,
	input  elem_drive_pkg::elem_cmd_t cmd_q,
	output elem_drive_pkg::env_addr_t env_addr,
	output elem_drive_pkg::frq_addr_t frq_addr,
	output logic                      gate,
	output logic                      done
);
	import elem_drive_pkg::*;

	seq_state_t state;
	env_addr_t  cnt;        // sample index on the address outputs, zero while idle
	env_addr_t  last_n;
	logic       last;
	logic       empty;

	assign last_n = cmd_q.env_len - 1'b1;
	assign empty = (cmd_q.env_len == '0);

	// sample 0 goes out in the start cycle itself
	assign gate = (state == SEQ_RUN) | (start & ~empty);
	assign last = gate & (cnt == last_n);

	// both addresses wrap modulo the table depth
	assign env_addr = cmd_q.env_start + cnt;
	assign frq_addr = cmd_q.frq_base + frq_addr_t'(cnt);

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			state <= SEQ_IDLE;
			cnt <= '0;
			done <= 1'b0;
		end else begin
			done <= last | (start & empty);
			case (state)
				SEQ_IDLE: begin
					if (gate && !last) begin    // length one finishes in the start cycle
						state <= SEQ_RUN;
						cnt <= env_addr_t'(1);
					end
				end
				SEQ_RUN: begin
					if (last) begin
						state <= SEQ_IDLE;
						cnt <= '0;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= SEQ_IDLE;
			endcase
		end
	end

endmodule

// File: verilog/elem_cmd_decode.sv
// per element command capture, takes a strobe only while idle and holds busy until the pulse drains
`timescale 1ns/100ps
`include "elem_drive_cfg.svh"

module elem_cmd_decode (
	input  logic                      elem,
	input  logic                      rst_n,
	input  logic                      cmd_stb,
	input  elem_drive_pkg::elem_cmd_t cmd,
	input  logic                      done,
	output logic                      start,
	output elem_drive_pkg::elem_cmd_t cmd_q,
	output logic                      busy
);

	// done comes one cycle after the last address, the table and the
	// modulator still hold this many cycles of samples behind it
	localparam int DRAIN = `TBL_LAT + `MOD_LAT - 1;

	logic             accept;
	logic             accept_q;
	logic [DRAIN-1:0] done_sr;

	assign accept = cmd_stb & ~busy;    // strobes during a pulse are dropped

	always_ff @(posedge elem or negedge rst_n) begin
		if (!rst_n) begin
			accept_q <= 1'b0;
			start <= 1'b0;
			busy <= 1'b0;
			done_sr <= '0;
		end else begin
			accept_q <= accept;
			start <= accept_q;              // one cycle after the accepting edge
			done_sr <= {done_sr[DRAIN-2:0], done};
			if (accept)
				busy <= 1'b1;
			else if (done_sr[DRAIN-1])
				busy <= 1'b0;               // last sample has left the modulator
		end
	end

	// command stays put for the whole pulse, the sequencer and
	// the modulator read it until busy drops
	always_ff @(posedge elem) begin
		if (accept)
			cmd_q <= cmd;
	end

endmodule

// File: verilog/elem_drive_pkg.sv
// sample, address, command and FSM types of the drive generator, imported by RTL and testbench
`include "elem_drive_cfg.svh"

package elem_drive_pkg;

	typedef logic signed [`SAMPLE_W-1:0] sample_t;
	typedef logic [`ENV_AW-1:0] env_addr_t;
	typedef logic [`FRQ_AW-1:0] frq_addr_t;
	typedef logic signed [`SAMPLE_W-1:0] amp_t;    // Q1.15, 0x7fff is near full scale

	// one complex sample; for the carrier table x is cos and y is sin
	typedef struct packed {
		sample_t x;
		sample_t y;
	} iq_t;

	// drive command, 40 bits
	typedef struct packed {
		env_addr_t env_start;
		env_addr_t env_len;     // zero gives no samples
		frq_addr_t frq_base;
		amp_t      amp;
	} elem_cmd_t;

	// host table write, 41 bits
	typedef struct packed {
		logic      sel;         // 0 envelope, 1 carrier
		env_addr_t addr;
		iq_t       data;
	} tbl_wr_t;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_RUN
	} seq_state_t;

endpackage

// File: verilog/elem_drive_cfg.svh
// table sizes, sample width and pipeline latencies of the drive generator, include where needed
`ifndef ELEM_DRIVE_CFG_SVH
`define ELEM_DRIVE_CFG_SVH

// table geometry
`define ENV_AW    8
`define FRQ_AW    8
`define ENV_DEPTH 256
`define FRQ_DEPTH 256

`define SAMPLE_W  16    // one signed x or y component

// latency pieces along one element chain, in clock cycles
`define CMD_LAT   1     // strobe edge to start pulse
`define TBL_LAT   1     // registered table read
`define MOD_LAT   2     // complex product, then amplitude
`define SUM_LAT   1     // element summer

// strobe edge to the first sample on out_iq
`define DRIVE_LAT (`CMD_LAT + `TBL_LAT + `MOD_LAT + `SUM_LAT)

`endif
